// ==== verilog/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

  // ============================
  // Widths and class encodings
  // ============================
  localparam int instrWidth = 32;

  localparam logic [1:0] opClassDp     = 2'b00; // Data processing, bits 27:26
  localparam logic [1:0] opClassMem    = 2'b01; // Single load/store
  localparam logic [1:0] opClassBranch = 2'b10; // B, offset is PC relative

  // NZCV in CPSR bit order, n is the MSB
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // Data-processing opcodes, value equals instruction bits 24:21
  typedef enum logic [3:0] {
    aluAnd, aluEor, aluSub, aluRsb,
    aluAdd, aluAdc, aluSbc, aluRsc,
    aluTst, aluTeq, aluCmp, aluCmn,
    aluOrr, aluMov, aluBic, aluMvn
  } aluOpT;

  // Condition field, bits 31:28
  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc,
    condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt,
    condGt, condLe, condAl, condNv
  } condT;

  // ============================
  // Stage payloads
  // ============================
  typedef struct packed {
    condT       cond;
    aluOpT      aluControl;
    logic       aluSrc;     // Operand B from the immediate
    logic [1:0] flagWrite;  // [1] NZ update, [0] CV update
    logic       regWrite;
    logic       memWrite;
    logic       memtoReg;
    logic       byteAccess;
    logic       branch;
    logic       pcSrc;      // Instruction writes the PC
  } ctrlET;

  // Already gated by the condition in Execute
  typedef struct packed {
    logic regWrite;
    logic memWrite;
    logic memtoReg;
    logic byteAccess;
    logic pcSrc;
  } ctrlMT;

  typedef struct packed {
    logic  regWrite;
    logic  memtoReg;
    logic  byteAccess;
    logic  pcSrc;
    flagsT flagsNext;       // Value the status register takes
    logic  setFlags;        // Status register load request
  } ctrlWT;

endpackage

`default_nettype wire

// ==== verilog/decodeBus.sv ====
`timescale 1ns/100ps
`default_nettype none

// Decoded controls, produced in Decode and packed into the Execute payload
interface decodeBus import ctrlPkg::*; ();
  logic [1:0] regSrc;     // Read-port selects for the register file
  logic [1:0] immSrc;     // Immediate extension format
  logic       aluSrc;
  aluOpT      aluControl;
  logic [1:0] flagWrite;  // {NZ, CV}
  logic       regWrite;
  logic       memWrite;
  logic       memtoReg;
  logic       byteAccess;
  logic       branch;
  logic       pcSrc;

  modport decoder (
    output regSrc, immSrc, aluSrc, aluControl, flagWrite,
    output regWrite, memWrite, memtoReg, byteAccess, branch, pcSrc
  );

  modport sink (
    input regSrc, immSrc, aluSrc, aluControl, flagWrite,
    input regWrite, memWrite, memtoReg, byteAccess, branch, pcSrc
  );
endinterface

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instrDecoder import ctrlPkg::*; (
  input  logic [instrWidth-1:0] instr,
  decodeBus.decoder             bus
);

  aluOpT dpOp;     // Opcode field of a data-processing instruction
  logic  arithOp;  // Opcode produces meaningful C and V
  logic  testOp;   // tst, teq, cmp, cmn

  assign dpOp = aluOpT'(instr[24:21]);

  // Arithmetic opcodes, the logical ones leave C and V alone
  always_comb begin
    case (dpOp)
      aluSub, aluRsb, aluAdd, aluAdc,
      aluSbc, aluRsc, aluCmp, aluCmn: arithOp = 1'b1;
      default:                        arithOp = 1'b0;
    endcase
  end

  assign testOp = (dpOp inside {aluTst, aluTeq, aluCmp, aluCmn}); // Flags only

  // ============================
  // Main decode
  // ============================
  always_comb begin
    // Defaults describe a no-op
    bus.regSrc     = 2'b00;
    bus.immSrc     = 2'b00;
    bus.aluSrc     = 1'b0;
    bus.aluControl = aluAdd;
    bus.flagWrite  = 2'b00;
    bus.regWrite   = 1'b0;
    bus.memWrite   = 1'b0;
    bus.memtoReg   = 1'b0;
    bus.byteAccess = 1'b0;
    bus.branch     = 1'b0;

    case (instr[27:26])
      opClassDp: begin
        bus.aluSrc       = instr[25];               // Immediate form
        bus.aluControl   = dpOp;
        bus.regWrite     = ~testOp;                 // Compares write no register
        bus.flagWrite[1] = instr[20];               // S bit
        bus.flagWrite[0] = instr[20] & arithOp;
      end
      opClassMem: begin
        bus.immSrc     = 2'b01;                     // 12-bit offset
        bus.aluSrc     = ~instr[25];                // I=0 means immediate offset
        bus.aluControl = instr[23] ? aluAdd : aluSub; // U bit
        bus.byteAccess = instr[22];
        bus.memtoReg   = instr[20];                 // Load
        bus.regWrite   = instr[20];
        bus.memWrite   = ~instr[20];                // Store
        bus.regSrc     = {~instr[20], 1'b0};        // Store reads Rd as data
      end
      opClassBranch: begin
        bus.regSrc     = 2'b01;                     // Rn is the PC
        bus.immSrc     = 2'b10;                     // 24-bit word offset
        bus.aluSrc     = 1'b1;
        bus.branch     = 1'b1;
      end
      default: ;                                    // Coprocessor space, no-op
    endcase

    // PC write by branch or by any result aimed at r15
    bus.pcSrc = bus.branch | (bus.regWrite & (instr[15:12] == 4'hF));
  end

endmodule

`default_nettype wire

// ==== verilog/stageReg.sv ====
`timescale 1ns/100ps
`default_nettype none

// Pipeline register shared by the three stage payloads
module stageReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    en,     // Low while the stage is stalled
  input  logic    flush,  // Inserts a bubble
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      q <= '0;            // All-zero payload is a bubble, flush beats stall
    end else if (en) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/condUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module condUnit import ctrlPkg::*; (
  input  ctrlET ctrlE,
  input  flagsT aluFlags,
  input  flagsT flagsM,
  input  logic  setFlagsM,
  input  flagsT flagsW,
  input  logic  setFlagsW,
  input  flagsT flagsCommitted,
  output ctrlMT ctrlM,
  output logic  branchTaken,
  output flagsT flagsNext,
  output logic  setFlags
);

  flagsT cur;     // Flags as seen by the instruction in Execute
  logic  condEx;  // Condition passed

  // Youngest pending flag write wins
  assign cur = setFlagsM ? flagsM : (setFlagsW ? flagsW : flagsCommitted);

  // ============================
  // Condition table
  // ============================
  always_comb begin
    case (ctrlE.cond)
      condEq:  condEx = cur.z;
      condNe:  condEx = ~cur.z;
      condCs:  condEx = cur.c;
      condCc:  condEx = ~cur.c;
      condMi:  condEx = cur.n;
      condPl:  condEx = ~cur.n;
      condVs:  condEx = cur.v;
      condVc:  condEx = ~cur.v;
      condHi:  condEx = cur.c & ~cur.z;
      condLs:  condEx = ~cur.c | cur.z;
      condGe:  condEx = (cur.n == cur.v);
      condLt:  condEx = (cur.n != cur.v);
      condGt:  condEx = ~cur.z & (cur.n == cur.v);
      condLe:  condEx = cur.z | (cur.n != cur.v);
      condAl:  condEx = 1'b1;
      condNv:  condEx = 1'b0;         // Never
      default: condEx = 1'b0;
    endcase
  end

  // NZ and CV merge separately, logical ops keep the old C and V
  assign flagsNext.n = ctrlE.flagWrite[1] ? aluFlags.n : cur.n;
  assign flagsNext.z = ctrlE.flagWrite[1] ? aluFlags.z : cur.z;
  assign flagsNext.c = ctrlE.flagWrite[0] ? aluFlags.c : cur.c;
  assign flagsNext.v = ctrlE.flagWrite[0] ? aluFlags.v : cur.v;
  assign setFlags    = (|ctrlE.flagWrite) & condEx;

  // Side effects only when the condition holds
  assign branchTaken      = ctrlE.branch & condEx;
  assign ctrlM.regWrite   = ctrlE.regWrite & condEx;
  assign ctrlM.memWrite   = ctrlE.memWrite & condEx;
  assign ctrlM.pcSrc      = ctrlE.pcSrc & condEx;
  assign ctrlM.memtoReg   = ctrlE.memtoReg;   // Harmless without regWrite
  assign ctrlM.byteAccess = ctrlE.byteAccess;

endmodule

`default_nettype wire

// ==== verilog/flagsReg.sv ====
`timescale 1ns/100ps
`default_nettype none

// Committed NZCV, the only architectural state here
module flagsReg import ctrlPkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  we,       // Writeback setFlags, held off while Writeback stalls
  input  flagsT flagsIn,
  output flagsT flags
);

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (we) begin
      flags <= flagsIn;   // Commit in Writeback
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pipeController.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipeController import ctrlPkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [instrWidth-1:0] instrD,
  input  logic [3:0]            aluFlagsE,
  input  logic                  stallE,
  input  logic                  flushE,
  input  logic                  stallM,
  input  logic                  flushM,
  input  logic                  stallW,
  input  logic                  flushW,
  output logic [1:0]            regSrcD,
  output logic [1:0]            immSrcD,
  output logic                  aluSrcE,
  output logic [3:0]            aluControlE,
  output logic                  branchTakenE,
  output logic                  memWriteM,
  output logic                  regWriteW,
  output logic                  memtoRegW,
  output logic                  byteAccessW,
  output logic                  pcSrcW,
  output logic [3:0]            flagsW,
  output logic                  pcWrPendingF
);

  // Memory stage also carries the flag result toward Writeback
  typedef struct packed {
    ctrlMT ctrl;
    flagsT flags;
    logic  setFlags;
  } memPayloadT;

  decodeBus   decBus ();
  ctrlET      ctrlD, ctrlE;
  ctrlMT      ctrlGatedE;
  memPayloadT memD, memM;
  ctrlWT      ctrlWD, ctrlW;
  flagsT      flagsNextE, flagsCommitted;
  logic       setFlagsE;

  // ============================
  // Decode
  // ============================
  instrDecoder iDecoder (.instr(instrD), .bus(decBus.decoder));

  assign regSrcD = decBus.regSrc;   // Same cycle as instrD
  assign immSrcD = decBus.immSrc;

  always_comb begin
    ctrlD.cond       = condT'(instrD[31:28]);
    ctrlD.aluControl = decBus.aluControl;
    ctrlD.aluSrc     = decBus.aluSrc;
    ctrlD.flagWrite  = decBus.flagWrite;
    ctrlD.regWrite   = decBus.regWrite;
    ctrlD.memWrite   = decBus.memWrite;
    ctrlD.memtoReg   = decBus.memtoReg;
    ctrlD.byteAccess = decBus.byteAccess;
    ctrlD.branch     = decBus.branch;
    ctrlD.pcSrc      = decBus.pcSrc;
  end

  // ============================
  // Execute
  // ============================
  stageReg #(.payloadT(ctrlET)) iRegE (
    .clk(clk), .rst(rst), .en(~stallE), .flush(flushE), .d(ctrlD), .q(ctrlE)
  );

  condUnit iCond (
    .ctrlE(ctrlE),
    .aluFlags(flagsT'(aluFlagsE)),
    .flagsM(memM.flags),            // Forwarded from Memory
    .setFlagsM(memM.setFlags),
    .flagsW(ctrlW.flagsNext),       // Forwarded from Writeback
    .setFlagsW(ctrlW.setFlags),
    .flagsCommitted(flagsCommitted),
    .ctrlM(ctrlGatedE),
    .branchTaken(branchTakenE),
    .flagsNext(flagsNextE),
    .setFlags(setFlagsE)
  );

  assign aluSrcE     = ctrlE.aluSrc;
  assign aluControlE = ctrlE.aluControl;

  // ============================
  // Memory
  // ============================
  assign memD = '{ctrl: ctrlGatedE, flags: flagsNextE, setFlags: setFlagsE};

  stageReg #(.payloadT(memPayloadT)) iRegM (
    .clk(clk), .rst(rst), .en(~stallM), .flush(flushM), .d(memD), .q(memM)
  );

  assign memWriteM = memM.ctrl.memWrite;

  // ============================
  // Writeback
  // ============================
  assign ctrlWD = '{regWrite:   memM.ctrl.regWrite,
                    memtoReg:   memM.ctrl.memtoReg,
                    byteAccess: memM.ctrl.byteAccess,
                    pcSrc:      memM.ctrl.pcSrc,
                    flagsNext:  memM.flags,
                    setFlags:   memM.setFlags};

  stageReg #(.payloadT(ctrlWT)) iRegW (
    .clk(clk), .rst(rst), .en(~stallW), .flush(flushW), .d(ctrlWD), .q(ctrlW)
  );

  flagsReg iFlags (
    .clk(clk), .rst(rst),
    .we(ctrlW.setFlags & ~stallW),  // One commit per instruction
    .flagsIn(ctrlW.flagsNext),
    .flags(flagsCommitted)
  );

  assign regWriteW   = ctrlW.regWrite;
  assign memtoRegW   = ctrlW.memtoReg;
  assign byteAccessW = ctrlW.byteAccess;
  assign pcSrcW      = ctrlW.pcSrc;
  assign flagsW      = flagsCommitted;

  // Fetch must wait while a PC write is in flight
  assign pcWrPendingF = decBus.pcSrc | ctrlE.pcSrc | memM.ctrl.pcSrc;

endmodule

`default_nettype wire

// ==== verif/tbVectors.svh ====
`ifndef tbVectorsSvh
`define tbVectorsSvh

// Each entry is one test issued on instrD at cycle c
// Execute checks at c+1, Memory at c+2, Writeback at c+3 and flags at c+4
// A stall on issue shifts every check by one cycle
typedef struct {
  string       name;
  logic [31:0] instr;
  logic [3:0]  aluFlags;  // Driven while the entry sits in Execute
  logic        chained;   // Issued the cycle after the previous entry without drain
  logic        stall;     // One-cycle stallE on issue
  logic        flush;     // flushE on issue turns the entry into a bubble
  logic [3:0]  srcD;      // {regSrcD, immSrcD} while the entry sits in Decode
  logic        aluSrc;    // aluSrcE
  logic [3:0]  aluCtl;    // aluControlE
  logic [5:0]  expCtl;    // {branchTakenE, memWriteM, regWriteW, memtoRegW, byteAccessW, pcSrcW}
  logic [3:0]  flags;     // flagsW {n, z, c, v} once the entry has committed
  logic [2:0]  pend;      // pcWrPendingF with the entry in {Decode, Execute, Memory}
} vecT;

localparam int numVec = 14;

vecT vecs [numVec] = '{
  //  name           instr         alu   ch st fl srcD    aS aluCtl expCtl  flags pend
  '{"adds imm",    32'hE2921001, 4'hB, 0, 0, 0, 4'b0000, 1, 4'h4, 6'b001000, 4'hB, 3'b000},
  '{"cmp reg",     32'hE1530004, 4'h6, 0, 0, 0, 4'b0000, 0, 4'hA, 6'b000000, 4'h6, 3'b000},
  '{"orrs NZ only", 32'hE1965007, 4'h9, 0, 0, 0, 4'b0000, 0, 4'hC, 6'b001000, 4'hA, 3'b000},
  '{"cmp gives Z", 32'hE1510001, 4'h4, 0, 0, 0, 4'b0000, 0, 4'hA, 6'b000000, 4'h4, 3'b000},
  '{"moveq fwd M", 32'h01A08009, 4'hF, 1, 0, 0, 4'b0000, 0, 4'hD, 6'b001000, 4'h4, 3'b000},
  '{"movne fwd W", 32'h11A0A00B, 4'hF, 1, 0, 0, 4'b0000, 0, 4'hD, 6'b000000, 4'h4, 3'b000},
  '{"str word",    32'hE5832004, 4'h0, 0, 0, 0, 4'b1001, 1, 4'h4, 6'b010000, 4'h4, 3'b000},
  '{"ldrb minus",  32'hE5554008, 4'h0, 0, 0, 0, 4'b0001, 1, 4'h2, 6'b001110, 4'h4, 3'b000},
  '{"ldr word",    32'hE5976000, 4'h0, 0, 0, 0, 4'b0001, 1, 4'h4, 6'b001100, 4'h4, 3'b000},
  '{"b taken",     32'hEA000010, 4'h0, 0, 0, 0, 4'b0110, 1, 4'h4, 6'b100001, 4'h4, 3'b111},
  '{"bne fails",   32'h1A000010, 4'h0, 0, 0, 0, 4'b0110, 1, 4'h4, 6'b000000, 4'h4, 3'b110},
  '{"mov pc",      32'hE1A0F000, 4'h0, 0, 0, 0, 4'b0000, 0, 4'hD, 6'b001001, 4'h4, 3'b111},
  '{"adds flushed", 32'hE2921001, 4'hF, 0, 0, 1, 4'b0000, 0, 4'h0, 6'b000000, 4'h4, 3'b000},
  '{"strb stalled", 32'hE5C32004, 4'h0, 0, 1, 0, 4'b1001, 1, 4'h4, 6'b010010, 4'h4, 3'b000}
};

`endif

// ==== verif/tbPipeController.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbPipeController;

  `include "tbVectors.svh"

  localparam int maxCyc     = numVec * 8;
  localparam int timeoutCyc = numVec * 8 + 50;  // Covers reset plus every entry with drain

  logic        clk, rst;
  logic [31:0] instrD;
  logic [3:0]  aluFlagsE;
  logic        stallE, flushE, stallM, flushM, stallW, flushW;
  logic [1:0]  regSrcD, immSrcD;
  logic        aluSrcE, branchTakenE, memWriteM;
  logic [3:0]  aluControlE, flagsW;
  logic        regWriteW, memtoRegW, byteAccessW, pcSrcW, pcWrPendingF;

  // Per-cycle stimulus and the entry checked in each slot (-1 for none)
  logic [31:0] schedInstr [maxCyc];
  logic [3:0]  schedAlu   [maxCyc];
  logic        schedStall [maxCyc];
  logic        schedFlush [maxCyc];
  int slotD [maxCyc];
  int slotE [maxCyc];
  int slotPreM [maxCyc];  // One cycle before memWriteM is due
  int slotM [maxCyc];
  int slotW [maxCyc];
  int slotF [maxCyc];
  int testErr [numVec + 1];  // Last index is the reset test
  int checks = 0;
  int errors = 0;
  int cycleCount = 0;
  integer seed;

  pipeController i_dut (
    .clk(clk), .rst(rst), .instrD(instrD), .aluFlagsE(aluFlagsE),
    .stallE(stallE), .flushE(flushE), .stallM(stallM), .flushM(flushM),
    .stallW(stallW), .flushW(flushW),
    .regSrcD(regSrcD), .immSrcD(immSrcD),
    .aluSrcE(aluSrcE), .aluControlE(aluControlE), .branchTakenE(branchTakenE),
    .memWriteM(memWriteM),
    .regWriteW(regWriteW), .memtoRegW(memtoRegW), .byteAccessW(byteAccessW),
    .pcSrcW(pcSrcW), .flagsW(flagsW), .pcWrPendingF(pcWrPendingF)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCyc) begin
      $display("Timeout: run did not finish within %0d cycles", timeoutCyc);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic checkValue(input int test, input string sig, input logic [31:0] actual,
                            input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      testErr[test]++;
      $display("FAIL test %0d %s: got 0x%0h, expected 0x%0h", test, sig, actual, expected);
    end
  endtask

  task automatic reportTest(input int test, input string name);
    $display("%s test %0d %s", (testErr[test] == 0) ? "ok  " : "BAD ", test, name);
  endtask

  // AL mov rd, rm without S
  // Rd stays off r15 so fillers never write the PC
  function automatic logic [31:0] randomFiller();
    int rd;
    int rm;
    rd = $unsigned($random(seed)) % 15;
    rm = $unsigned($random(seed)) % 16;
    return 32'hE1A0_0000 | (rd << 12) | rm;
  endfunction

  initial begin
    int c, i, issue, nextCyc, d, failedTests;
    clk = 1'b0;
    rst = 1'b1;
    instrD = 32'hE1A0_0000;  // mov r0, r0
    aluFlagsE = 4'h0;
    {stallE, flushE, stallM, flushM, stallW, flushW} = '0;
    seed = 32'ha37f_4543;
    failedTests = 0;

    // ==============================
    // Build the cycle schedule
    // ==============================
    for (c = 0; c < maxCyc; c++) begin
      schedInstr[c] = randomFiller();
      schedAlu[c] = 4'h0;
      schedStall[c] = 1'b0;
      schedFlush[c] = 1'b0;
      slotD[c] = -1;
      slotE[c] = -1;
      slotPreM[c] = -1;
      slotM[c] = -1;
      slotW[c] = -1;
      slotF[c] = -1;
    end
    for (i = 0; i <= numVec; i++) testErr[i] = 0;
    issue = 0;
    nextCyc = 0;
    for (i = 0; i < numVec; i++) begin
      issue = vecs[i].chained ? issue + 1 : nextCyc;
      d = vecs[i].stall;
      schedInstr[issue] = vecs[i].instr;
      schedInstr[issue + d] = vecs[i].instr;  // Held in Decode over the stall
      schedStall[issue] = vecs[i].stall;
      schedFlush[issue] = vecs[i].flush;
      schedAlu[issue + 1 + d] = vecs[i].aluFlags;
      slotD[issue] = i;
      slotE[issue + 1 + d] = i;
      slotPreM[issue + 1 + d] = i;
      slotM[issue + 2 + d] = i;
      slotW[issue + 3 + d] = i;
      slotF[issue + 4 + d] = i;
      nextCyc = issue + 6 + d;                // Drain before the next independent entry
    end

    // ==============================
    // Reset
    // ==============================
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checkValue(numVec, "aluSrcE", aluSrcE, 0);
    checkValue(numVec, "aluControlE", aluControlE, 0);
    checkValue(numVec, "branchTakenE", branchTakenE, 0);
    checkValue(numVec, "memWriteM", memWriteM, 0);
    checkValue(numVec, "regWriteW", regWriteW, 0);
    checkValue(numVec, "memtoRegW", memtoRegW, 0);
    checkValue(numVec, "byteAccessW", byteAccessW, 0);
    checkValue(numVec, "pcSrcW", pcSrcW, 0);
    checkValue(numVec, "flagsW", flagsW, 0);
    checkValue(numVec, "pcWrPendingF", pcWrPendingF, 0);
    reportTest(numVec, "reset");

    // ==============================
    // Run the schedule
    // ==============================
    for (c = 0; c < nextCyc; c++) begin
      @(posedge clk);
      instrD <= schedInstr[c];
      aluFlagsE <= schedAlu[c];
      stallE <= schedStall[c];
      flushE <= schedFlush[c];
      @(negedge clk);                         // Outputs settled after the edge
      if (slotD[c] >= 0) begin
        i = slotD[c];
        checkValue(i, "regSrcD", regSrcD, vecs[i].srcD[3:2]);
        checkValue(i, "immSrcD", immSrcD, vecs[i].srcD[1:0]);
        checkValue(i, "pcWrPendingF", pcWrPendingF, vecs[i].pend[2]);
      end
      if (slotE[c] >= 0) begin
        i = slotE[c];
        checkValue(i, "aluSrcE", aluSrcE, vecs[i].aluSrc);
        checkValue(i, "aluControlE", aluControlE, vecs[i].aluCtl);
        checkValue(i, "branchTakenE", branchTakenE, vecs[i].expCtl[5]);
        checkValue(i, "pcWrPendingF", pcWrPendingF, vecs[i].pend[1]);
      end
      if (slotPreM[c] >= 0) checkValue(slotPreM[c], "memWriteM early", memWriteM, 0);
      if (slotM[c] >= 0) begin
        i = slotM[c];
        checkValue(i, "memWriteM", memWriteM, vecs[i].expCtl[4]);
        checkValue(i, "pcWrPendingF", pcWrPendingF, vecs[i].pend[0]);
      end
      if (slotW[c] >= 0) begin
        i = slotW[c];
        checkValue(i, "regWriteW", regWriteW, vecs[i].expCtl[3]);
        checkValue(i, "memtoRegW", memtoRegW, vecs[i].expCtl[2]);
        checkValue(i, "byteAccessW", byteAccessW, vecs[i].expCtl[1]);
        checkValue(i, "pcSrcW", pcSrcW, vecs[i].expCtl[0]);
      end
      if (slotF[c] >= 0) begin
        i = slotF[c];
        checkValue(i, "flagsW", flagsW, vecs[i].flags);
        reportTest(i, vecs[i].name);         // Flags slot is the last one
      end
    end

    for (i = 0; i <= numVec; i++) begin
      if (testErr[i] != 0) failedTests++;
    end
    $display("Tests %0d, failed %0d, checks %0d, mismatches %0d",
             numVec + 1, failedTests, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verif
verilog/ctrlPkg.sv
verilog/decodeBus.sv
verilog/instrDecoder.sv
verilog/stageReg.sv
verilog/condUnit.sv
verilog/flagsReg.sv
verilog/pipeController.sv
verif/tbPipeController.sv

// ==== Bender.yml ====
package:
  name: pipe_controller

sources:
  - verilog/ctrlPkg.sv
  - verilog/decodeBus.sv
  - verilog/instrDecoder.sv
  - verilog/stageReg.sv
  - verilog/condUnit.sv
  - verilog/flagsReg.sv
  - verilog/pipeController.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tbPipeController.sv
